/* files.f */
+incdir+hw
hw/fpslice_pkg.sv
hw/fp_lane_if.sv
hw/fp_noncomp_lane.sv
hw/fp_noncomp_slice.sv
hw/fp_noncomp_top.sv
verification/fp_slice_checker.sv
verification/tb_fp_noncomp_top.sv

/* hw/fp_lane_if.sv */
/* Request and response bundle between the slice and one lane
   The slice drives the request and output ready, the lane answers the rest */
`timescale 1ns/1ns

interface fp_lane_if
  import fpslice_pkg::*;
();

  // Request towards the lane
  fp_lane_t   op_a;
  fp_lane_t   op_b;
  fp_op_e     op;
  fp_tag_t    tag;
  logic       vec;      // Vector flag, carried along as aux data
  logic       mask;     // SIMD mask bit of this lane
  logic       in_valid;
  logic       out_ready;

  // Response from the lane
  logic       in_ready;
  fp_lane_t   result;
  fp_status_t status;
  logic       ext_bit;
  fp_class_e  class_mask;
  logic       is_class;
  fp_tag_t    tag_out;
  logic       vec_out;
  logic       mask_out;
  logic       out_valid;
  logic       busy;     // Any stage occupied

  modport slice (output op_a, op_b, op, tag, vec, mask, in_valid, out_ready,
                 input  in_ready, result, status, ext_bit, class_mask, is_class,
                        tag_out, vec_out, mask_out, out_valid, busy);

  modport lane (input  op_a, op_b, op, tag, vec, mask, in_valid, out_ready,
                output in_ready, result, status, ext_bit, class_mask, is_class,
                       tag_out, vec_out, mask_out, out_valid, busy);

endinterface

/* hw/fp_noncomp_lane.sv */
/* Single binary16 lane for min/max, sign injection, compares and classify
   The result is formed on entry and carried through a stallable stage chain */
`timescale 1ns/1ns
`include "fpslice_consts.svh"

module fp_noncomp_lane
  import fpslice_pkg::*;
(
  input logic     clk_i,
  input logic     rst_i,
  fp_lane_if.lane lane
);

  localparam int unsigned NUM_STAGES = `FP_PIPE_REGS;
  localparam int unsigned SIGN_BIT   = `FP_LANE_W - 1;
  localparam int unsigned MAN_W      = 10; // binary16 mantissa

  typedef struct packed {
    fp_lane_t   result;
    fp_status_t status;
    logic       ext_bit;
    fp_class_e  class_mask;
    logic       is_class;
    fp_tag_t    tag;
    logic       vec;
    logic       mask;
  } lane_payload_t;

  function automatic fp_class_e classify(input fp_lane_t val);
    logic      exp_ones;
    logic      exp_zero;
    logic      man_zero;
    fp_class_e cls;
    exp_ones = &val[SIGN_BIT-1:MAN_W];
    exp_zero = ~|val[SIGN_BIT-1:MAN_W];
    man_zero = ~|val[MAN_W-1:0];
    if (exp_ones && !man_zero) begin
      cls = val[MAN_W-1] ? QNAN : SNAN; // Top mantissa bit marks a quiet NaN
    end else if (exp_ones) begin
      cls = val[SIGN_BIT] ? NEGINF : POSINF;
    end else if (exp_zero && man_zero) begin
      cls = val[SIGN_BIT] ? NEGZERO : POSZERO;
    end else if (exp_zero) begin
      cls = val[SIGN_BIT] ? NEGSUBNORM : POSSUBNORM;
    end else begin
      cls = val[SIGN_BIT] ? NEGNORM : POSNORM;
    end
    return cls;
  endfunction

  fp_class_e     class_a;
  fp_class_e     class_b;
  logic          a_nan;
  logic          b_nan;
  logic          any_nan;
  logic          any_snan;
  logic          both_zero;
  logic          a_less;    // Total order with -0 below +0
  logic          ieee_eq;
  logic          ieee_lt;
  lane_payload_t entry;

  logic [NUM_STAGES-1:0] stage_valid;
  logic [NUM_STAGES-1:0] stage_ready; // Stage can take new data this cycle
  lane_payload_t         stage_data [NUM_STAGES];

  // --------------------------------------------------------------------------
  // Operand analysis
  // --------------------------------------------------------------------------
  assign class_a   = classify(lane.op_a);
  assign class_b   = classify(lane.op_b);
  assign a_nan     = class_a inside {SNAN, QNAN};
  assign b_nan     = class_b inside {SNAN, QNAN};
  assign any_nan   = a_nan | b_nan;
  assign any_snan  = (class_a == SNAN) | (class_b == SNAN);
  assign both_zero = ~|{lane.op_a[SIGN_BIT-1:0], lane.op_b[SIGN_BIT-1:0]};

  // Sign first, then magnitude, reversed for two negatives
  assign a_less = (lane.op_a[SIGN_BIT] != lane.op_b[SIGN_BIT]) ? lane.op_a[SIGN_BIT] :
                  lane.op_a[SIGN_BIT] ? (lane.op_b[SIGN_BIT-1:0] < lane.op_a[SIGN_BIT-1:0]) :
                                        (lane.op_a[SIGN_BIT-1:0] < lane.op_b[SIGN_BIT-1:0]);

  // Compares follow IEEE, so the two zeros are equal
  assign ieee_lt = a_less & ~both_zero;
  assign ieee_eq = (lane.op_a == lane.op_b) | both_zero;

  always_comb begin : compute_entry
    entry            = '0;
    entry.ext_bit    = 1'b1; // FP result unless a compare or class
    entry.class_mask = class_a;
    entry.tag        = lane.tag;
    entry.vec        = lane.vec;
    entry.mask       = lane.mask;
    case (lane.op)
      OP_MIN, OP_MAX: begin
        if (a_nan && b_nan) begin
          entry.result = `FP_CANON_NAN;
        end else if (a_nan) begin
          entry.result = lane.op_b;
        end else if (b_nan) begin
          entry.result = lane.op_a;
        end else begin
          entry.result = (a_less ^ (lane.op == OP_MAX)) ? lane.op_a : lane.op_b;
        end
        entry.status[`FP_NV_BIT] = any_snan;
      end
      OP_SGNJ:  entry.result = {lane.op_b[SIGN_BIT], lane.op_a[SIGN_BIT-1:0]};
      OP_SGNJN: entry.result = {~lane.op_b[SIGN_BIT], lane.op_a[SIGN_BIT-1:0]};
      OP_SGNJX: entry.result = {lane.op_a[SIGN_BIT] ^ lane.op_b[SIGN_BIT],
                                lane.op_a[SIGN_BIT-1:0]};
      OP_EQ: begin
        entry.result             = fp_lane_t'(ieee_eq & ~any_nan);
        entry.status[`FP_NV_BIT] = any_snan; // Quiet compare
        entry.ext_bit            = 1'b0;
      end
      OP_LT, OP_LE: begin
        entry.result             = fp_lane_t'((ieee_lt | (ieee_eq & (lane.op == OP_LE)))
                                              & ~any_nan);
        entry.status[`FP_NV_BIT] = any_nan;  // Signaling compare
        entry.ext_bit            = 1'b0;
      end
      OP_CLASS: begin
        entry.is_class = 1'b1;
        entry.ext_bit  = 1'b0;
      end
      default: entry.ext_bit = 1'b0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Stage chain
  // --------------------------------------------------------------------------
  always_comb begin : ready_chain
    stage_ready[NUM_STAGES-1] = ~stage_valid[NUM_STAGES-1] | lane.out_ready;
    for (int s = int'(NUM_STAGES) - 2; s >= 0; s--) begin
      stage_ready[s] = ~stage_valid[s] | stage_ready[s+1];
    end
  end

  for (genvar s = 0; s < NUM_STAGES; s++) begin : gen_stages
    logic          src_valid; // Data offered to this stage
    lane_payload_t src_data;

    if (s == 0) begin : gen_from_input
      assign src_valid = lane.in_valid;
      assign src_data  = entry;
    end else begin : gen_from_prev
      assign src_valid = stage_valid[s-1];
      assign src_data  = stage_data[s-1];
    end

    always_ff @(posedge clk_i) begin : stage_ctrl
      if (rst_i) begin
        stage_valid[s] <= 1'b0;
      end else if (stage_ready[s]) begin
        stage_valid[s] <= src_valid;
      end
    end

    always_ff @(posedge clk_i) begin : stage_payload
      if (stage_ready[s] && src_valid) begin
        stage_data[s] <= src_data;
      end
    end
  end

  assign lane.in_ready   = stage_ready[0];
  assign lane.out_valid  = stage_valid[NUM_STAGES-1];
  assign lane.result     = stage_data[NUM_STAGES-1].result;
  assign lane.status     = stage_data[NUM_STAGES-1].status;
  assign lane.ext_bit    = stage_data[NUM_STAGES-1].ext_bit;
  assign lane.class_mask = stage_data[NUM_STAGES-1].class_mask;
  assign lane.is_class   = stage_data[NUM_STAGES-1].is_class;
  assign lane.tag_out    = stage_data[NUM_STAGES-1].tag;
  assign lane.vec_out    = stage_data[NUM_STAGES-1].vec;
  assign lane.mask_out   = stage_data[NUM_STAGES-1].mask;
  assign lane.busy       = |stage_valid;

endmodule

/* hw/fp_noncomp_slice.sv */
/* binary16 format slice with two lanes in a 32-bit word
   Splits operands over the lanes and packs results, class blocks and status */
`timescale 1ns/1ns
`include "fpslice_consts.svh"

module fp_noncomp_slice
  import fpslice_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  fp_word_t      operand_a_i,
  input  fp_word_t      operand_b_i,
  input  fp_op_e        op_i,
  input  logic          vectorial_i,
  input  fp_simd_mask_t simd_mask_i,
  input  fp_tag_t       tag_i,
  input  logic          in_valid_i,
  output logic          in_ready_o,
  output fp_word_t      result_o,
  output fp_status_t    status_o,
  output logic          ext_bit_o,
  output fp_tag_t       tag_o,
  output logic          out_valid_o,
  input  logic          out_ready_i,
  output logic          busy_o
);

  localparam int unsigned NUM_LANES = `FP_NUM_LANES;
  localparam int unsigned LANE_W    = `FP_LANE_W;
  localparam int unsigned BLK_W     = `FP_CLASS_BLK_W;

  logic       head_in_ready;  // Lane 0 sets the pace
  logic       head_out_valid;
  logic       head_ext_bit;
  logic       head_vec;
  logic       head_is_class;
  fp_class_e  head_class;
  logic       result_is_vector;

  logic       [NUM_LANES-1:0] lane_busy;
  fp_status_t [NUM_LANES-1:0] lane_status; // Already masked

  fp_word_t   slice_result;
  fp_word_t   vec_class_result;
  fp_word_t   class_result;

  assign result_is_vector = head_out_valid & head_vec;

  // --------------------------------------------------------------------------
  // Lanes
  // --------------------------------------------------------------------------
  for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lanes
    fp_lane_if lane_bus ();
    logic      lane_used;  // Lane output takes part in this result
    logic      block_sign;
    fp_class_e cls;

    assign lane_bus.op_a = operand_a_i[g*LANE_W +: LANE_W];
    assign lane_bus.op_b = operand_b_i[g*LANE_W +: LANE_W];
    assign lane_bus.op   = op_i;
    assign lane_bus.tag  = tag_i;
    assign lane_bus.vec  = vectorial_i;
    assign lane_bus.mask = simd_mask_i[g];

    if (g == 0) begin : gen_head
      assign lane_bus.in_valid  = in_valid_i;
      assign lane_bus.out_ready = out_ready_i;
      assign lane_used          = lane_bus.out_valid;
      assign head_in_ready      = lane_bus.in_ready;
      assign head_out_valid     = lane_bus.out_valid;
      assign head_ext_bit       = lane_bus.ext_bit;
      assign head_vec           = lane_bus.vec_out;
      assign head_is_class      = lane_bus.is_class;
      assign head_class         = lane_bus.class_mask;
      assign tag_o              = lane_bus.tag_out;
    end else begin : gen_upper
      // Vector ops only, accepted on the same edge as lane 0
      assign lane_bus.in_valid  = in_valid_i & vectorial_i & head_in_ready;
      assign lane_bus.out_ready = out_ready_i & result_is_vector;
      assign lane_used          = lane_bus.out_valid & result_is_vector;
    end

    fp_noncomp_lane i_lane (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .lane  (lane_bus)
    );

    // Unused lanes carry the NaN box or zero extension
    assign slice_result[g*LANE_W +: LANE_W] = lane_used ? lane_bus.result
                                                        : {LANE_W{head_ext_bit}};
    assign lane_status[g] = (lane_used & lane_bus.mask_out) ? lane_bus.status : '0;
    assign lane_busy[g]   = lane_bus.busy;

    // 8-bit class block, sign in bit 7 down to infinity in bit 0
    assign cls        = lane_bus.class_mask;
    assign block_sign = cls inside {NEGINF, NEGNORM, NEGSUBNORM, NEGZERO};
    assign vec_class_result[g*BLK_W +: BLK_W] = {
      block_sign,
      ~block_sign,
      cls == QNAN,
      cls == SNAN,
      cls inside {POSZERO, NEGZERO},
      cls inside {POSSUBNORM, NEGSUBNORM},
      cls inside {POSNORM, NEGNORM},
      cls inside {POSINF, NEGINF}
    };
  end

  // --------------------------------------------------------------------------
  // Output assembly
  // --------------------------------------------------------------------------
  assign vec_class_result[`FP_WORD_W-1:NUM_LANES*BLK_W] = '0;

  assign class_result = result_is_vector ? vec_class_result : fp_word_t'(head_class);
  assign result_o     = head_is_class ? class_result : slice_result;

  assign in_ready_o  = head_in_ready;
  assign out_valid_o = head_out_valid;
  assign ext_bit_o   = head_ext_bit;
  assign busy_o      = |lane_busy;

  always_comb begin : collapse_status
    status_o = '0;
    for (int i = 0; i < int'(NUM_LANES); i++) begin
      status_o |= lane_status[i];
    end
  end

endmodule

/* hw/fp_noncomp_top.sv */
/* Top level of the binary16 noncomp unit with plain ports
   Wraps the format slice without adding any stage */
`timescale 1ns/1ns

module fp_noncomp_top
  import fpslice_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  fp_word_t      operand_a_i,
  input  fp_word_t      operand_b_i,
  input  fp_op_e        op_i,
  input  logic          vectorial_i,  // Use both lanes
  input  fp_simd_mask_t simd_mask_i,
  input  fp_tag_t       tag_i,
  input  logic          in_valid_i,
  output logic          in_ready_o,
  output fp_word_t      result_o,
  output fp_status_t    status_o,
  output logic          ext_bit_o,
  output fp_tag_t       tag_o,
  output logic          out_valid_o,
  input  logic          out_ready_i,
  output logic          busy_o        // Operations in flight
);

  fp_noncomp_slice i_fp_noncomp_slice (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .vectorial_i (vectorial_i),
    .simd_mask_i (simd_mask_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .ext_bit_o   (ext_bit_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

endmodule

/* hw/fpslice_consts.svh */
/* Widths, depths and constants shared by the binary16 noncomp slice
   Include wherever a width, the pipeline depth or the canonical NaN is needed */
`ifndef FPSLICE_CONSTS_SVH
`define FPSLICE_CONSTS_SVH

// --------------------------------------------------------------------------
// Datapath geometry
// --------------------------------------------------------------------------
`define FP_LANE_W      16 // One binary16 value
`define FP_NUM_LANES   2
`define FP_WORD_W      32 // Operand and result word
`define FP_TAG_W       4

// Stages in each lane, any value of 1 or more works
`define FP_PIPE_REGS   2

// Status and class encodings
`define FP_STATUS_W    5  // NV DZ OF UF NX
`define FP_NV_BIT      4
`define FP_CLASS_W     10 // One-hot class mask
`define FP_CLASS_BLK_W 8  // Packed class block per lane in vector results

`define FP_CANON_NAN   16'h7E00 // Quiet NaN for min/max of two NaNs

`endif

/* hw/fpslice_pkg.sv */
/* Types for the binary16 noncomp slice, lanes and top level
   Pulled in by a wildcard import in each module header */
package fpslice_pkg;

  `include "fpslice_consts.svh"

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------
  typedef logic [`FP_WORD_W-1:0]    fp_word_t;      // Packed operand or result
  typedef logic [`FP_LANE_W-1:0]    fp_lane_t;      // Single binary16 value
  typedef logic [`FP_STATUS_W-1:0]  fp_status_t;    // NV DZ OF UF NX
  typedef logic [`FP_TAG_W-1:0]     fp_tag_t;
  typedef logic [`FP_NUM_LANES-1:0] fp_simd_mask_t; // One bit per lane

  // Operations of the noncomp opgroup
  typedef enum logic [3:0] {
    OP_MIN,
    OP_MAX,
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_EQ,
    OP_LT,
    OP_LE,
    OP_CLASS
  } fp_op_e;

  // One-hot class of a single value
  typedef enum logic [`FP_CLASS_W-1:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } fp_class_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and decide the verdict from the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_fp_noncomp_top \
  --Mdir obj_dir \
  -f files.f

# The log decides, so a failing run must not stop the script here
./obj_dir/Vtb_fp_noncomp_top > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  echo "Simulation FAILED, see $LOG"
  exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
  echo "Simulation ended without a verdict, see $LOG"
  exit 1
fi
echo "Simulation PASSED"

/* verification/fp_slice_checker.sv */
/* Handshake and reset assertions for the noncomp top level
   Attached to every fp_noncomp_top instance by the bind at the end */
`timescale 1ns/1ns

module fp_slice_checker
  import fpslice_pkg::*;
(
  input logic     clk_i,
  input logic     rst_i,
  input logic     in_ready_o,
  input fp_word_t result_o,
  input logic     out_valid_o,
  input logic     out_ready_i,
  input logic     busy_o
);

  // Stalled result stays put until taken
  held_result: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o))
    else $error("result_o or out_valid_o changed while out_ready_i was low");

  busy_with_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o |-> busy_o)
    else $error("out_valid_o high while busy_o low");

  // Empty pipeline right after reset
  clean_reset: assert property (@(posedge clk_i)
    rst_i |=> !out_valid_o && !busy_o && in_ready_o)
    else $error("pipeline not empty in the cycle after reset");

endmodule

bind fp_noncomp_top fp_slice_checker i_fp_slice_checker (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .in_ready_o  (in_ready_o),
  .result_o    (result_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .busy_o      (busy_o)
);

/* verification/tb_fp_noncomp_top.sv */
/* Self-checking testbench for the binary16 noncomp top level
   Special and random operands, random back-pressure, reference model and scoreboard */
`timescale 1ns/1ns
`include "fpslice_consts.svh"

module tb_fp_noncomp_top
  import fpslice_pkg::*;
();

  localparam int TIMEOUT = 1000; // Cycles allowed for any single wait

  typedef struct packed {
    fp_word_t    result;
    fp_status_t  status;
    logic        ext_bit;
    fp_tag_t     tag;
    logic        strict;  // Accepted while out_ready_i was held high
    int unsigned cycle;
  } expect_t;

  logic          clk_i = 1'b0;
  logic          rst_i;
  fp_word_t      operand_a_i;
  fp_word_t      operand_b_i;
  fp_op_e        op_i;
  logic          vectorial_i;
  fp_simd_mask_t simd_mask_i;
  fp_tag_t       tag_i;
  logic          in_valid_i;
  logic          in_ready_o;
  fp_word_t      result_o;
  fp_status_t    status_o;
  logic          ext_bit_o;
  fp_tag_t       tag_o;
  logic          out_valid_o;
  logic          out_ready_i = 1'b0;
  logic          busy_o;

  expect_t     pending [$];
  int unsigned cycle = 0;
  logic        hold_ready = 1'b0;
  int          accepted = 0;
  int          returned = 0;

  fp_noncomp_top i_fp_noncomp_top (.*);

  initial begin : clock_gen
    forever #10 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  // Class as 0..9 in one-hot bit order
  function automatic int class_index(input fp_lane_t v);
    int idx;
    if (v[14:10] == 5'h1f) begin
      if (v[9:0] == '0) idx = v[15] ? 0 : 7;
      else idx = v[9] ? 9 : 8;     // Quiet bit set
    end else if (v[14:10] == 5'h00) begin
      if (v[9:0] == '0) idx = v[15] ? 3 : 4;
      else idx = v[15] ? 2 : 5;
    end else begin
      idx = v[15] ? 1 : 6;
    end
    return idx;
  endfunction

  // Signed key in value order with zeros equal or -0 below +0
  function automatic int order_key(input fp_lane_t v, input logic zeros_equal);
    int mag;
    mag = int'(v[14:0]);
    if (!v[15]) return mag;
    return zeros_equal ? -mag : -mag - 1;
  endfunction

  function automatic void lane_model(input fp_lane_t a, input fp_lane_t b, input fp_op_e op,
                                     output fp_lane_t res, output logic nv);
    logic nan_a;
    logic nan_b;
    logic snan;
    nan_a = class_index(a) >= 8;
    nan_b = class_index(b) >= 8;
    snan  = (class_index(a) == 8) || (class_index(b) == 8);
    res   = '0;
    nv    = 1'b0;
    case (op)
      OP_MIN, OP_MAX: begin
        nv = snan;
        if (nan_a && nan_b) res = `FP_CANON_NAN;
        else if (nan_a) res = b;
        else if (nan_b) res = a;
        else if ((order_key(a, 1'b0) < order_key(b, 1'b0)) == (op == OP_MIN)) res = a;
        else res = b;
      end
      OP_SGNJ:  res = {b[15], a[14:0]};
      OP_SGNJN: res = {~b[15], a[14:0]};
      OP_SGNJX: res = {a[15] ^ b[15], a[14:0]};
      OP_EQ: begin
        nv  = snan;
        res = fp_lane_t'(!(nan_a || nan_b) && order_key(a, 1'b1) == order_key(b, 1'b1));
      end
      OP_LT, OP_LE: begin
        nv = nan_a || nan_b;
        if (!nv && op == OP_LT) res = fp_lane_t'(order_key(a, 1'b1) < order_key(b, 1'b1));
        if (!nv && op == OP_LE) res = fp_lane_t'(order_key(a, 1'b1) <= order_key(b, 1'b1));
      end
      default: res = '0;  // Class word is built by the caller
    endcase
  endfunction

  // Sign, not-sign, qNaN, sNaN, zero, subnormal, normal, inf
  function automatic logic [7:0] class_block(input int idx);
    logic neg;
    neg = idx < 4;
    return {neg, ~neg, idx == 9, idx == 8, idx == 3 || idx == 4, idx == 2 || idx == 5,
            idx == 1 || idx == 6, idx == 0 || idx == 7};
  endfunction

  function automatic expect_t expected_result(input fp_word_t a, input fp_word_t b,
                                              input fp_op_e op, input logic vec,
                                              input fp_simd_mask_t mask, input fp_tag_t tag);
    expect_t  e;
    fp_lane_t r0;
    fp_lane_t r1;
    logic     nv0;
    logic     nv1;
    lane_model(a[15:0], b[15:0], op, r0, nv0);
    lane_model(a[31:16], b[31:16], op, r1, nv1);
    e         = '0;
    e.tag     = tag;
    e.ext_bit = op inside {OP_MIN, OP_MAX, OP_SGNJ, OP_SGNJN, OP_SGNJX};
    if (op == OP_CLASS && vec) begin
      e.result = {16'h0000, class_block(class_index(a[31:16])), class_block(class_index(a[15:0]))};
    end else if (op == OP_CLASS) begin
      e.result = fp_word_t'(10'b1 << class_index(a[15:0]));
    end else begin
      e.result = {vec ? r1 : {16{e.ext_bit}}, r0}; // NaN box or zero extension
    end
    e.status[`FP_NV_BIT] = (nv0 && mask[0]) || (nv1 && mask[1] && vec);
    return e;
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  function automatic fp_lane_t special_value(input int k);
    case (k)
      0:       return 16'h0000; // +0
      1:       return 16'h8000; // -0
      2:       return 16'h7C00; // +inf
      3:       return 16'hFC00;
      4:       return 16'h7C01; // sNaN
      5:       return 16'h7E00; // qNaN
      6:       return 16'h0001; // Smallest subnormal
      7:       return 16'h83FF;
      8:       return 16'h3C00; // +1.0
      default: return 16'hBC00;
    endcase
  endfunction

  function automatic fp_lane_t pick_lane();
    if ($urandom_range(1) == 0) return special_value(int'($urandom_range(9)));
    return 16'($urandom);
  endfunction

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input fp_word_t got, input fp_word_t exp, input string what);
    if (got !== exp) begin
      stop_on_failure($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_status(input fp_status_t got, input fp_status_t exp, input string what);
    if (got !== exp) begin
      stop_on_failure($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_tag(input fp_tag_t got, input fp_tag_t exp, input string what);
    if (got !== exp) begin
      stop_on_failure($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_failure($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_latency(input int unsigned got, input logic strict);
    if ((strict && got != `FP_PIPE_REGS) || got < `FP_PIPE_REGS) begin
      stop_on_failure($sformatf("MISMATCH at %0t: latency %0d cycles, pipeline depth %0d",
                                $time, got, `FP_PIPE_REGS));
    end
  endtask

  // Called at a falling edge and returns at the falling edge after the transfer
  task automatic send_op(input fp_word_t a, input fp_word_t b, input fp_op_e op, input logic vec);
    int start;
    int waited;
    start       = accepted;
    operand_a_i = a;
    operand_b_i = b;
    op_i        = op;
    vectorial_i = vec;
    simd_mask_i = 2'($urandom);
    tag_i       = 4'($urandom);
    in_valid_i  = 1'b1;
    waited      = 0;
    while (accepted == start) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) stop_on_failure("Timeout: the DUT never accepted an operation");
    end
    if (!hold_ready && $urandom_range(3) == 0) begin
      in_valid_i = 1'b0;  // Idle cycle
      @(negedge clk_i);
    end
  endtask

  task automatic drain();
    int waited;
    in_valid_i = 1'b0;
    waited     = 0;
    while (pending.size() != 0 || busy_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > TIMEOUT) stop_on_failure("Timeout: the pipeline did not drain");
    end
  endtask

  // --------------------------------------------------------------------------
  // Back-pressure and scoreboard
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin : drive_out_ready
    out_ready_i = hold_ready || ($urandom_range(2) != 0); // Low about a third of the time
  end

  always @(posedge clk_i) begin : scoreboard
    expect_t incoming;
    expect_t head;
    cycle <= cycle + 1;
    if (!rst_i && out_valid_o && out_ready_i) begin
      if (pending.size() == 0) stop_on_failure("The DUT returned a result with nothing in flight");
      head = pending.pop_front();
      check_word(result_o, head.result, "result");
      check_status(status_o, head.status, "status");
      check_bit(ext_bit_o, head.ext_bit, "ext bit");
      check_tag(tag_o, head.tag, "tag");
      check_latency(cycle - head.cycle, head.strict);
      returned++;
    end
    if (!rst_i && in_valid_i && in_ready_o) begin
      incoming        = expected_result(operand_a_i, operand_b_i, op_i, vectorial_i,
                                        simd_mask_i, tag_i);
      incoming.strict = hold_ready;
      incoming.cycle  = cycle;
      pending.push_back(incoming);
      accepted++;
    end
  end

  initial begin : stimulus
    void'($urandom(32'h9a5d));
    rst_i       = 1'b1;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = OP_MIN;
    vectorial_i = 1'b0;
    simd_mask_i = '0;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;

    // All special pairs for every op in scalar and then vector mode
    for (int v = 0; v < 2; v++) begin
      for (int o = 0; o <= 8; o++) begin
        for (int i = 0; i < 10; i++) begin
          for (int j = 0; j < 10; j++) begin
            send_op({v != 0 ? special_value(j) : pick_lane(), special_value(i)},
                    {v != 0 ? special_value(i) : pick_lane(), special_value(j)},
                    fp_op_e'(4'(o)), v[0]);
          end
        end
      end
    end

    repeat (2000) begin
      send_op({pick_lane(), pick_lane()}, {pick_lane(), pick_lane()},
              fp_op_e'(4'($urandom_range(8))), 1'($urandom));
    end
    drain();

    // Back-to-back with out_ready_i held high so the latency must be exact
    hold_ready <= 1'b1;
    @(negedge clk_i);
    repeat (64) begin
      send_op({pick_lane(), pick_lane()}, {pick_lane(), pick_lane()},
              fp_op_e'(4'($urandom_range(8))), 1'($urandom));
    end
    drain();
    hold_ready <= 1'b0;

    $display("all tests passed");
    $finish;
  end

endmodule
